/* mac_cluster_input.txt */
// columns: kind_lane_prec_accum_addr_data_expected, kind 0 weight, 1 job, 2 job paired with next
// kind 3 reset, f end; prec 0 is 8-bit, 1 is 16-bit, 2 is 32-bit; data is weight or activation
0_0_0_0_0_02FE03FD7F8001FF_0000000000000000
0_0_0_0_1_FFFF010080000003_0000000000000000
0_0_0_0_2_FFFFFFFD00010000_0000000000000000
0_0_0_0_3_7F7F7F7F7F7F7F7F_0000000000000000
1_0_0_0_0_0303FEFE02028080_06FAFA06FE008080
1_0_1_0_1_123401000002FFFE_EDCC00000000FFFA
1_0_2_0_2_0000000500010001_FFFFFFF100010000
1_0_0_0_3_0101010101010101_7F7F7F7F7F7F7F7F
1_0_0_1_3_0101010101010101_FEFEFEFEFEFEFEFE
1_0_0_1_3_0202020202020202_FCFCFCFCFCFCFCFC
1_0_1_1_1_0001000100010001_FCFBFDFC7CFCFCFF
2_0_2_0_2_0000000200000003_FFFFFFFA00030000
2_1_0_0_0_0101010101010101_02FE03FD7F8001FF
2_0_2_1_2_0000000200000003_FFFFFFF400060000
2_1_1_1_1_0002000100010002_02FC04FDFF800205
3_0_0_0_0_0000000000000000_0000000000000000
1_0_0_1_0_0101010101010101_02FE03FD7F8001FF
1_1_1_1_3_0001000100010001_7F7F7F7F7F7F7F7F
F_0_0_0_0_0000000000000000_0000000000000000

/* verilog.f */
mac_cfg_pkg.sv
mac_bus_pkg.sv
simd_mul.sv
mac_lane.sv
weight_arbiter.sv
weight_mem.sv
mac_cluster_top.sv
mac_cluster_assertions.sv
tb_mac_cluster.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mac_cluster \
  --Mdir obj_dir -o sim_mac_cluster

sim_out=$(./obj_dir/sim_mac_cluster) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi

/* tb_mac_cluster.sv */
// testbench for the mac cluster; loads weights and runs the jobs listed in the input file
`timescale 1ns/100ps

module tb_mac_cluster;
  import mac_cfg_pkg::*;
  import mac_bus_pkg::*;

  logic                          clk;
  logic                          rst_i;
  logic                          wr_en;
  logic [waddr_w_lp-1:0]         wr_addr;
  logic [data_w_lp-1:0]          wr_data;
  logic [num_lanes_lp-1:0]       job_req;
  mac_job_s [num_lanes_lp-1:0]   job_in;
  logic [num_lanes_lp-1:0]       job_ack;
  mac_res_s [num_lanes_lp-1:0]   res_out;

  logic [147:0] recs [32];  // kind, lane, prec, accum, addr, data, expected
  integer       seed;       // gaps between parallel requests
  bit           run_over;   // a result line has been printed

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  mac_cluster_top UUT (
    .clk       (clk),
    .rst_i     (rst_i),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .job_req_i (job_req),
    .job_i     (job_in),
    .job_ack_o (job_ack),
    .res_o     (res_out)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic mac_job_s decode_job(input logic [147:0] rec);
    mac_job_s j;
    j.activation = rec[127:64];
    j.waddr      = rec[131:128];
    j.prec       = prec_e'(rec[137:136]);  // low two bits of the prec nibble
    j.accum      = rec[132];
    return j;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    run_over = 1'b1;
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic write_weight(input logic [3:0] addr, input logic [63:0] data);
    wr_en   = 1'b1;   // written on the next rising edge
    wr_addr = addr;
    wr_data = data;
    @(negedge clk);
    wr_en   = 1'b0;
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (2) @(negedge clk);
    rst_i = 1'b0;
  endtask

  // one four-phase job, starts and ends on a falling edge
  task automatic run_job(input logic lane, input logic [147:0] rec, input int gap,
                         input string name);
    repeat (gap) @(negedge clk);
    check_value({name, " ack idle"}, 64'd0, {63'd0, job_ack[lane]});
    job_in[lane]  = decode_job(rec);
    job_req[lane] = 1'b1;
    @(negedge clk);
    while (!job_ack[lane]) @(negedge clk);       // watchdog guards this wait
    check_value(name, rec[63:0], res_out[lane].result);
    @(negedge clk);
    check_value({name, " ack held"}, 64'd1, {63'd0, job_ack[lane]});
    check_value({name, " result held"}, rec[63:0], res_out[lane].result);
    job_req[lane] = 1'b0;
    @(negedge clk);
    while (job_ack[lane]) @(negedge clk);        // ack drops only after req is gone
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int i;
    int n_jobs;
    int gap0;
    int gap1;
    rst_i    = 1'b1;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    job_req  = '0;
    job_in   = '0;
    seed     = 635;
    run_over = 1'b0;
    $readmemh("mac_cluster_input.txt", recs);
    n_jobs = 0;
    for (i = 0; i < $size(recs); i++) begin
      if (recs[i][147:144] == 4'h1 || recs[i][147:144] == 4'h2) n_jobs++;
    end
    fork
      begin
        repeat (n_jobs * 40) @(posedge clk);
        abort_run("timeout, a job handshake did not complete");
      end
    join_none
    repeat (2) @(negedge clk);                   // 2 reset cycles
    rst_i = 1'b0;
    i = 0;
    while (recs[i][147:144] != 4'hF) begin
      case (recs[i][147:144])
        4'h0: write_weight(recs[i][131:128], recs[i][127:64]);
        4'h1: run_job(recs[i][140], recs[i], 0, $sformatf("job line %0d", i));
        4'h2: begin                              // this line and the next one together
          gap0 = $unsigned($random(seed)) % 4;
          gap1 = $unsigned($random(seed)) % 4;
          fork
            run_job(recs[i][140], recs[i], gap0, $sformatf("job line %0d", i));
            run_job(recs[i+1][140], recs[i+1], gap1, $sformatf("job line %0d", i + 1));
          join
          i++;
        end
        4'h3: apply_reset();
        default: abort_run($sformatf("input file has an unknown record kind on line %0d", i));
      endcase
      i++;
    end
    $display("RESULT: PASS");
    run_over = 1'b1;
    $finish;
  end

  // an assertion stop still ends with a verdict line
  final begin
    if (!run_over) begin
      $display("RESULT: FAIL");
    end
  end

endmodule

/* mac_cluster_assertions.sv */
// concurrent checks on the job handshake and the weight grants, bound into the lanes and the arbiter
`timescale 1ns/100ps

module mac_cluster_assertions (
  input logic                                 clk,
  input logic                                 rst_i,
  input logic                                 req_i,  // job_req_i of a lane
  input logic                                 ack_i,  // job_ack_o of a lane
  input logic [mac_cfg_pkg::data_w_lp-1:0]    res_i,  // result word of a lane
  input logic [mac_cfg_pkg::num_lanes_lp-1:0] gnt_i   // read grants
);

  //////////////////////////////////////////////////
  // arbiter grants
  //////////////////////////////////////////////////
  grant_onehot: assert property (@(posedge clk) disable iff (rst_i) $onehot0(gnt_i))
    else $error("more than one lane granted in the same cycle");

  //////////////////////////////////////////////////
  // job handshake
  //////////////////////////////////////////////////
  ack_needs_req: assert property (@(posedge clk) disable iff (rst_i) $rose(ack_i) |-> req_i)
    else $error("job_ack_o rose while job_req_i was low");

  // the result must not move while the requester may still be reading it
  res_held: assert property (@(posedge clk) disable iff (rst_i)
    (ack_i && $past(ack_i)) |-> $stable(res_i))
    else $error("res_o changed while job_ack_o was high");

endmodule

// lane side, its single grant sits in bit 0
bind mac_lane mac_cluster_assertions u_lane_checks (
  .clk   (clk),
  .rst_i (rst_i),
  .req_i (job_req_i),
  .ack_i (job_ack_o),
  .res_i (res_o.result),
  .gnt_i ({1'b0, rd_gnt_i})
);

bind weight_arbiter mac_cluster_assertions u_arb_checks (
  .clk   (clk),
  .rst_i (rst_i),
  .req_i (1'b0),     // no job handshake here
  .ack_i (1'b0),
  .res_i ('0),
  .gnt_i (gnt_o)
);

/* mac_cluster_top.sv */
// cluster top level: two mac lanes sharing one weight memory through the round-robin arbiter
`timescale 1ns/100ps

module mac_cluster_top (
  input  logic                                                   clk,
  input  logic                                                   rst_i,
  input  logic                                                   wr_en_i,    // weight load
  input  logic [mac_cfg_pkg::waddr_w_lp-1:0]                     wr_addr_i,
  input  logic [mac_cfg_pkg::data_w_lp-1:0]                      wr_data_i,
  input  logic [mac_cfg_pkg::num_lanes_lp-1:0]                   job_req_i,  // one per lane
  input  mac_bus_pkg::mac_job_s [mac_cfg_pkg::num_lanes_lp-1:0]  job_i,
  output logic [mac_cfg_pkg::num_lanes_lp-1:0]                   job_ack_o,
  output mac_bus_pkg::mac_res_s [mac_cfg_pkg::num_lanes_lp-1:0]  res_o
);
  import mac_cfg_pkg::*;
  import mac_bus_pkg::*;

  logic [num_lanes_lp-1:0]     rd_req;     // lane to arbiter
  wrd_req_s [num_lanes_lp-1:0] rd_addr;
  logic [num_lanes_lp-1:0]     rd_gnt;     // arbiter to lane
  logic                        mem_rd_en;
  logic [waddr_w_lp-1:0]       mem_addr;
  logic [data_w_lp-1:0]        rd_data;    // broadcast to every lane

  //////////////////////////////////////////////////
  // lanes
  //////////////////////////////////////////////////
  for (genvar l = 0; l < num_lanes_lp; l++) begin : g_lane
    mac_lane u_lane (
      .clk       (clk),
      .rst_i     (rst_i),
      .job_req_i (job_req_i[l]),
      .job_i     (job_i[l]),
      .job_ack_o (job_ack_o[l]),
      .res_o     (res_o[l]),
      .rd_req_o  (rd_req[l]),
      .rd_addr_o (rd_addr[l]),
      .rd_gnt_i  (rd_gnt[l]),
      .rd_data_i (rd_data)
    );
  end

  weight_arbiter u_arb (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (rd_req),
    .addr_i      (rd_addr),
    .gnt_o       (rd_gnt),
    .mem_rd_en_o (mem_rd_en),
    .mem_addr_o  (mem_addr)
  );

  weight_mem u_wmem (
    .clk       (clk),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_en_i   (mem_rd_en),
    .rd_addr_i (mem_addr),
    .rd_data_o (rd_data)
  );

endmodule

/* weight_mem.sv */
// shared weight storage, written from outside before jobs run and read by the granted lane
`timescale 1ns/100ps

module weight_mem (
  input  logic                               clk,
  input  logic                               wr_en_i,    // takes effect on this edge
  input  logic [mac_cfg_pkg::waddr_w_lp-1:0] wr_addr_i,
  input  logic [mac_cfg_pkg::data_w_lp-1:0]  wr_data_i,
  input  logic                               rd_en_i,    // from the arbiter grant
  input  logic [mac_cfg_pkg::waddr_w_lp-1:0] rd_addr_i,
  output logic [mac_cfg_pkg::data_w_lp-1:0]  rd_data_o   // one cycle after rd_en_i
);
  import mac_cfg_pkg::*;

  logic [data_w_lp-1:0] mem [wmem_depth_lp];  // 16 x 64 words

  //////////////////////////////////////////////////
  // write and registered read
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];  // holds between reads
    end
  end

endmodule

/* weight_arbiter.sv */
// round-robin arbiter that gives one lane per cycle the read port of the weight memory
`timescale 1ns/100ps

module weight_arbiter (
  input  logic                                      clk,
  input  logic                                      rst_i,
  input  logic [mac_cfg_pkg::num_lanes_lp-1:0]      req_i,   // lane read requests
  input  mac_bus_pkg::wrd_req_s [mac_cfg_pkg::num_lanes_lp-1:0] addr_i,  // per-lane address
  output logic [mac_cfg_pkg::num_lanes_lp-1:0]      gnt_o,   // one-hot or zero
  output logic                                      mem_rd_en_o,
  output logic [mac_cfg_pkg::waddr_w_lp-1:0]        mem_addr_o
);
  import mac_cfg_pkg::*;

  logic                    last_q;  // lane granted most recently
  logic [num_lanes_lp-1:0] gnt;

  //////////////////////////////////////////////////
  // grant select
  //////////////////////////////////////////////////
  // single requester is granted at once, a tie goes to the lane not served last
  always_comb begin
    gnt = req_i;
    if (&req_i) begin
      gnt = last_q ? 2'b01 : 2'b10;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      last_q <= 1'b0;
    end else if (|gnt) begin
      last_q <= gnt[1];  // remember winner
    end
  end

  assign gnt_o       = gnt;
  assign mem_rd_en_o = |gnt;
  assign mem_addr_o  = gnt[1] ? addr_i[1].waddr : addr_i[0].waddr;  // address of the winner

endmodule

/* mac_lane.sv */
// one mac lane: takes a job over req/ack, fetches its weight, multiplies and loads or accumulates
`timescale 1ns/100ps

module mac_lane (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic                              job_req_i,  // four-phase request
  input  mac_bus_pkg::mac_job_s             job_i,      // held stable while job_req_i is high
  output logic                              job_ack_o,  // high while res_o is valid
  output mac_bus_pkg::mac_res_s             res_o,
  output logic                              rd_req_o,   // weight read request to arbiter
  output mac_bus_pkg::wrd_req_s             rd_addr_o,
  input  logic                              rd_gnt_i,   // one-cycle grant
  input  logic [mac_cfg_pkg::data_w_lp-1:0] rd_data_i   // shared read data, valid after grant
);
  import mac_cfg_pkg::*;

  typedef enum logic [2:0] {
    st_idle,     // wait for job_req_i
    st_fetch,    // rd_req_o high until granted
    st_wait,     // weight word on rd_data_i, multiplier samples it
    st_mul,      // product moving to stage 2
    st_done,     // product valid, accumulator written at end of cycle
    st_release   // ack high until requester drops job_req_i
  } state_e;

  state_e               state_q;
  logic [data_w_lp-1:0] acc_q;   // persists across jobs
  logic [data_w_lp-1:0] prod;    // multiplier output
  logic                 mul_ce;

  // sub-word add, carries stop at each sub-word boundary
  function automatic logic [data_w_lp-1:0] sub_add(input logic [data_w_lp-1:0] x,
                                                   input logic [data_w_lp-1:0] y,
                                                   input prec_e p);
    logic [data_w_lp-1:0] s;
    s = '0;
    case (p)
      prec_16: begin
        for (int i = 0; i < 4; i++) begin
          s[16*i +: 16] = x[16*i +: 16] + y[16*i +: 16];
        end
      end
      prec_32: begin
        for (int i = 0; i < 2; i++) begin
          s[32*i +: 32] = x[32*i +: 32] + y[32*i +: 32];
        end
      end
      default: begin  // reserved code runs as 8-bit
        for (int i = 0; i < 8; i++) begin
          s[8*i +: 8] = x[8*i +: 8] + y[8*i +: 8];
        end
      end
    endcase
    return s;
  endfunction

  //////////////////////////////////////////////////
  // job FSM and accumulator
  //////////////////////////////////////////////////
  // without contention ack rises on the 5th edge after job_req_i rises
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= st_idle;
      acc_q   <= '0;
    end else begin
      case (state_q)
        st_idle:    if (job_req_i) state_q <= st_fetch;
        st_fetch:   if (rd_gnt_i) state_q <= st_wait;   // memory answers next cycle
        st_wait:    state_q <= st_mul;
        st_mul:     state_q <= st_done;
        st_done: begin
          acc_q   <= job_i.accum ? sub_add(acc_q, prod, job_i.prec) : prod;
          state_q <= st_release;
        end
        st_release: if (!job_req_i) state_q <= st_idle;  // ack drops, next job may start
        default:    state_q <= st_idle;
      endcase
    end
  end

  assign mul_ce = (state_q == st_wait);  // only this lane's data is on the bus now

  simd_mul u_mul (
    .clk    (clk),
    .rst_i  (rst_i),
    .ce_i   (mul_ce),
    .prec_i (job_i.prec),
    .a_i    (job_i.activation),
    .b_i    (rd_data_i),
    .p_o    (prod)
  );

  assign job_ack_o = (state_q == st_release);
  assign res_o     = '{result: acc_q};           // acc_q only moves in st_done
  assign rd_req_o  = (state_q == st_fetch);      // drops the cycle after the grant
  assign rd_addr_o = '{waddr: job_i.waddr};

endmodule

/* simd_mul.sv */
// two-stage packed signed multiplier with precision select, used by each mac lane
`timescale 1ns/100ps

module simd_mul (
  input  logic                              clk,
  input  logic                              rst_i,   // clears both stages
  input  logic                              ce_i,    // stage 1 load enable
  input  mac_cfg_pkg::prec_e                prec_i,  // sub-word split for these operands
  input  logic [mac_cfg_pkg::data_w_lp-1:0] a_i,     // activation word
  input  logic [mac_cfg_pkg::data_w_lp-1:0] b_i,     // weight word
  output logic [mac_cfg_pkg::data_w_lp-1:0] p_o      // products, each kept to sub-word width
);
  import mac_cfg_pkg::*;

  logic [data_w_lp-1:0] a_q;         // stage 1 operands
  logic [data_w_lp-1:0] b_q;
  prec_e                prec_q;      // precision travels with its operands
  logic signed [15:0]   m8  [8];     // full 8x8 products
  logic signed [31:0]   m16 [4];     // full 16x16 products
  logic signed [63:0]   m32 [2];     // full 32x32 products
  logic [data_w_lp-1:0] prod;        // selected and truncated products

  //////////////////////////////////////////////////
  // stage 1, operand capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      a_q    <= '0;
      b_q    <= '0;
      prec_q <= prec_8;
    end else if (ce_i) begin
      a_q    <= a_i;
      b_q    <= b_i;
      prec_q <= prec_i;
    end
  end

  // one behavioral multiplier per sub-word and precision, operands sign-extended to product width
  for (genvar g = 0; g < 8; g++) begin : g_m8
    assign m8[g] = 16'($signed(a_q[8*g +: 8])) * 16'($signed(b_q[8*g +: 8]));
  end

  for (genvar g = 0; g < 4; g++) begin : g_m16
    assign m16[g] = 32'($signed(a_q[16*g +: 16])) * 32'($signed(b_q[16*g +: 16]));
  end

  for (genvar g = 0; g < 2; g++) begin : g_m32
    assign m32[g] = 64'($signed(a_q[32*g +: 32])) * 64'($signed(b_q[32*g +: 32]));
  end

  // low half of each product stays in its own sub-word slot
  always_comb begin
    prod = '0;
    case (prec_q)
      prec_16: begin
        for (int i = 0; i < 4; i++) begin
          prod[16*i +: 16] = m16[i][15:0];  // wrap to 16 bits
        end
      end
      prec_32: begin
        for (int i = 0; i < 2; i++) begin
          prod[32*i +: 32] = m32[i][31:0];  // wrap to 32 bits
        end
      end
      default: begin                        // prec_8 and the reserved code
        for (int i = 0; i < 8; i++) begin
          prod[8*i +: 8] = m8[i][7:0];
        end
      end
    endcase
  end

  //////////////////////////////////////////////////
  // stage 2, product register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      p_o <= '0;
    end else begin
      p_o <= prod;  // follows stage 1, stable while stage 1 holds
    end
  end

endmodule

/* mac_bus_pkg.sv */
// packed job, result and weight read bundles passed between the cluster ports, lanes and arbiter
package mac_bus_pkg;

  //////////////////////////////////////////////////
  // job handshake payloads
  //////////////////////////////////////////////////
  // 71 bits, activation sits in the msbs
  typedef struct packed {
    logic [mac_cfg_pkg::data_w_lp-1:0]  activation;  // packed signed sub-words
    logic [mac_cfg_pkg::waddr_w_lp-1:0] waddr;       // weight word to multiply with
    mac_cfg_pkg::prec_e                 prec;        // sub-word split
    logic                               accum;       // 1 adds to accumulator, 0 loads it
  } mac_job_s;

  typedef struct packed {
    logic [mac_cfg_pkg::data_w_lp-1:0] result;  // accumulator contents after the job
  } mac_res_s;

  //////////////////////////////////////////////////
  // weight memory read request
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [mac_cfg_pkg::waddr_w_lp-1:0] waddr;  // forwarded by the arbiter on grant
  } wrd_req_s;

endpackage

/* mac_cfg_pkg.sv */
// shared widths, memory depth and precision codes, imported by every RTL block and the testbench
package mac_cfg_pkg;

  //////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////
  localparam int data_w_lp     = 64;  // activation, weight and result word
  localparam int wmem_depth_lp = 16;  // weight words in the shared memory
  localparam int waddr_w_lp    = 4;   // log2 of wmem_depth_lp
  localparam int num_lanes_lp  = 2;   // mac lanes sharing the weight memory

  //////////////////////////////////////////////////
  // precision select
  //////////////////////////////////////////////////
  // code 2'b11 is reserved, the multiplier and the accumulator run it as prec_8
  typedef enum logic [1:0] {
    prec_8  = 2'b00,  // eight signed 8-bit sub-words
    prec_16 = 2'b01,  // four signed 16-bit sub-words
    prec_32 = 2'b10   // two signed 32-bit sub-words
  } prec_e;

endpackage
